// File: bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
	input  logic                    clock,
	input  logic                    rst,
	mem_bus_if.arbiter              fetch_bus,
	mem_bus_if.arbiter              lsu_bus,
	output logic                    mem_req_valid,
	input  logic                    mem_req_ready,
	output logic [rv_pkg::xlen-1:0] mem_addr,
	output logic [rv_pkg::xlen-1:0] mem_wdata,
	output logic [3:0]              mem_wstrb,
	output logic                    mem_we,
	input  logic                    mem_resp_valid,
	input  logic [rv_pkg::xlen-1:0] mem_rdata,
	input  logic                    mem_resp_err
);

	logic busy;      // request accepted, response pending
	logic owner_lsu;
	logic pick_fetch;

	assign pick_fetch = fetch_bus.req_valid; // fetch wins a tie

	assign mem_req_valid = !busy && (fetch_bus.req_valid || lsu_bus.req_valid);
	assign mem_addr      = pick_fetch ? fetch_bus.addr  : lsu_bus.addr;
	assign mem_wdata     = pick_fetch ? fetch_bus.wdata : lsu_bus.wdata;
	assign mem_wstrb     = pick_fetch ? fetch_bus.wstrb : lsu_bus.wstrb;
	assign mem_we        = pick_fetch ? fetch_bus.we    : lsu_bus.we;

	assign fetch_bus.req_ready = !busy && mem_req_ready;
	assign lsu_bus.req_ready   = !busy && mem_req_ready && !pick_fetch;

	always_ff @(posedge clock) begin
		if (rst) begin
			busy      <= 1'b0;
			owner_lsu <= 1'b0;
		end else if (mem_req_valid && mem_req_ready) begin
			busy      <= 1'b1;
			owner_lsu <= !pick_fetch;
		end else if (mem_resp_valid) begin
			busy <= 1'b0;
		end
	end

	// Response goes back to the owner only
	assign fetch_bus.resp_valid = mem_resp_valid && busy && !owner_lsu;
	assign lsu_bus.resp_valid   = mem_resp_valid && busy && owner_lsu;
	assign fetch_bus.rdata      = mem_rdata;
	assign lsu_bus.rdata        = mem_rdata;
	assign fetch_bus.resp_err   = mem_resp_err;
	assign lsu_bus.resp_err     = mem_resp_err;

endmodule

// File: decoder.sv
`timescale 1ns/1ps

module decoder (
	input  logic [rv_pkg::xlen-1:0] inst,
	output rv_pkg::decoded_t        dec
);

	logic [rv_pkg::xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	logic [2:0]              funct3;
	logic [6:0]              funct7;
	rv_pkg::alu_op_e         f3_op;
	logic                    f3_ok;
	logic                    bad_reg;

	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	// ALU op shared by OP and OP-IMM
	always_comb begin
		f3_ok = 1'b1;
		case (funct3)
			3'b000:  f3_op = rv_pkg::alu_add;
			3'b010:  f3_op = rv_pkg::alu_slt;
			3'b100:  f3_op = rv_pkg::alu_xor;
			3'b110:  f3_op = rv_pkg::alu_or;
			3'b111:  f3_op = rv_pkg::alu_and;
			default: begin
				f3_op = rv_pkg::alu_add;
				f3_ok = 1'b0; // shifts and SLTIU not supported
			end
		endcase
	end

	always_comb begin
		dec        = '0;
		dec.opcode = rv_pkg::opcode_e'(inst[6:0]);
		dec.rd     = inst[10:7];
		dec.rs1    = inst[18:15];
		dec.rs2    = inst[23:20];
		dec.funct3 = funct3;
		dec.alu_op = rv_pkg::alu_add;
		bad_reg    = 1'b0;
		case (dec.opcode)
			rv_pkg::op_lui: begin
				dec.imm = imm_u; dec.alu_op = rv_pkg::alu_pass_b; dec.reg_wen = 1'b1;
				bad_reg = inst[11];
			end
			rv_pkg::op_auipc: begin
				dec.imm = imm_u; dec.reg_wen = 1'b1; bad_reg = inst[11];
			end
			rv_pkg::op_jal: begin
				dec.imm = imm_j; dec.reg_wen = 1'b1; dec.is_jump = 1'b1;
				bad_reg = inst[11];
			end
			rv_pkg::op_jalr: begin
				dec.imm = imm_i; dec.reg_wen = 1'b1; dec.is_jump = 1'b1;
				dec.illegal = funct3 != 3'b000;
				bad_reg = inst[11] | inst[19];
			end
			rv_pkg::op_branch: begin
				dec.imm = imm_b; dec.is_branch = 1'b1;
				dec.illegal = funct3[2:1] == 2'b01; // 010 and 011 unused
				bad_reg = inst[19] | inst[24];
			end
			rv_pkg::op_load: begin
				dec.imm = imm_i; dec.reg_wen = 1'b1; dec.is_load = 1'b1;
				dec.illegal = funct3 != 3'b010; // LW only
				bad_reg = inst[11] | inst[19];
			end
			rv_pkg::op_store: begin
				dec.imm = imm_s; dec.is_store = 1'b1;
				dec.illegal = funct3 != 3'b010;
				bad_reg = inst[19] | inst[24];
			end
			rv_pkg::op_imm: begin
				dec.imm = imm_i; dec.reg_wen = 1'b1; dec.alu_op = f3_op;
				dec.illegal = !f3_ok;
				bad_reg = inst[11] | inst[19];
			end
			rv_pkg::op_reg: begin
				dec.reg_wen = 1'b1;
				if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
					dec.alu_op = rv_pkg::alu_sub;
				end else begin
					dec.alu_op  = f3_op;
					dec.illegal = !f3_ok || funct7 != 7'b0000000;
				end
				bad_reg = inst[11] | inst[19] | inst[24];
			end
			rv_pkg::op_system: begin
				if (inst == 32'h0010_0073)
					dec.is_ebreak = 1'b1;
				else
					dec.illegal = 1'b1; // no ECALL or CSR access
			end
			default: dec.illegal = 1'b1;
		endcase
		dec.illegal = dec.illegal | bad_reg;
	end

endmodule

// File: execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
	input  rv_pkg::decoded_t        dec,
	input  logic [rv_pkg::xlen-1:0] src1,
	input  logic [rv_pkg::xlen-1:0] src2,
	input  logic [rv_pkg::xlen-1:0] pc,
	output logic [rv_pkg::xlen-1:0] result,
	output logic [rv_pkg::xlen-1:0] pc_next,
	output logic [rv_pkg::xlen-1:0] mem_addr
);

	logic [rv_pkg::xlen-1:0] alu_a, alu_b, alu_out;
	logic [rv_pkg::xlen-1:0] pc_plus4;
	logic                    taken;

	assign alu_a    = (dec.opcode == rv_pkg::op_auipc) ? pc : src1;
	assign alu_b    = (dec.opcode == rv_pkg::op_reg) ? src2 : dec.imm;
	assign pc_plus4 = pc + 32'd4;
	assign mem_addr = src1 + dec.imm;

	always_comb begin
		case (dec.alu_op)
			rv_pkg::alu_sub: alu_out = alu_a - alu_b;
			rv_pkg::alu_slt: alu_out = {31'b0, $signed(alu_a) < $signed(alu_b)};
			rv_pkg::alu_and: alu_out = alu_a & alu_b;
			rv_pkg::alu_or:  alu_out = alu_a | alu_b;
			rv_pkg::alu_xor: alu_out = alu_a ^ alu_b;
			rv_pkg::alu_pass_b: alu_out = alu_b; // LUI
			default: alu_out = alu_a + alu_b;
		endcase
	end

	// ============================================================
	// Branch compare and next PC
	// ============================================================
	always_comb begin
		case (dec.funct3)
			3'b000:  taken = src1 == src2;
			3'b001:  taken = src1 != src2;
			3'b100:  taken = $signed(src1) < $signed(src2);
			3'b101:  taken = $signed(src1) >= $signed(src2);
			3'b110:  taken = src1 < src2;
			3'b111:  taken = src1 >= src2;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		if (dec.is_jump && dec.opcode == rv_pkg::op_jalr)
			pc_next = {mem_addr[rv_pkg::xlen-1:1], 1'b0};
		else if (dec.is_jump || (dec.is_branch && taken))
			pc_next = pc + dec.imm;
		else
			pc_next = pc_plus4;
	end

	assign result = dec.is_jump ? pc_plus4 : alu_out; // link address for jumps

endmodule

// File: fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
	parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
	input  logic                    clock,
	input  logic                    rst,
	mem_bus_if.requester            bus,
	input  logic                    start,
	input  logic [rv_pkg::xlen-1:0] pc_next,
	input  logic                    pc_load,
	output logic [rv_pkg::xlen-1:0] pc,
	output logic [rv_pkg::xlen-1:0] inst,
	output logic                    done,
	output logic                    error
);

	// Instruction reads only
	assign bus.addr  = pc;
	assign bus.wdata = '0;
	assign bus.wstrb = 4'b0000;
	assign bus.we    = 1'b0;

	always_ff @(posedge clock) begin
		if (rst) begin
			pc            <= reset_pc;
			bus.req_valid <= 1'b0;
		end else begin
			if (pc_load)
				pc <= pc_next;
			if (start)
				bus.req_valid <= 1'b1;
			else if (bus.req_valid && bus.req_ready)
				bus.req_valid <= 1'b0; // accepted, wait for response
		end
	end

	always_ff @(posedge clock) begin
		if (bus.resp_valid)
			inst <= bus.rdata;
	end

	assign done  = bus.resp_valid;
	assign error = bus.resp_valid && bus.resp_err;

endmodule

// File: load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit (
	input  logic                    clock,
	input  logic                    rst,
	mem_bus_if.requester            bus,
	input  logic                    start,
	input  rv_pkg::decoded_t        dec,
	input  logic [rv_pkg::xlen-1:0] addr,
	input  logic [rv_pkg::xlen-1:0] store_data,
	output logic [rv_pkg::xlen-1:0] load_data,
	output logic                    done,
	output logic                    error
);

	// Word accesses only, low address bits ignored
	assign bus.addr  = {addr[rv_pkg::xlen-1:2], 2'b00};
	assign bus.wdata = store_data;
	assign bus.we    = dec.opcode == rv_pkg::op_store;
	assign bus.wstrb = bus.we ? 4'b1111 : 4'b0000;

	always_ff @(posedge clock) begin
		if (rst)
			bus.req_valid <= 1'b0;
		else if (start)
			bus.req_valid <= 1'b1;
		else if (bus.req_valid && bus.req_ready)
			bus.req_valid <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (bus.resp_valid)
			load_data <= bus.rdata; // held until writeback
	end

	assign done  = bus.resp_valid;
	assign error = bus.resp_valid && bus.resp_err;

endmodule

// File: mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if;

	// Request channel
	logic                     req_valid;
	logic                     req_ready;
	logic [rv_pkg::xlen-1:0]  addr;
	logic [rv_pkg::xlen-1:0]  wdata;
	logic [3:0]               wstrb;
	logic                     we;

	// Response is one cycle wide with no ready
	logic                     resp_valid;
	logic [rv_pkg::xlen-1:0]  rdata;
	logic                     resp_err;

	modport requester (
		output req_valid, addr, wdata, wstrb, we,
		input  req_ready, resp_valid, rdata, resp_err
	);

	modport arbiter (
		input  req_valid, addr, wdata, wstrb, we,
		output req_ready, resp_valid, rdata, resp_err
	);

endinterface

// File: project.f
rv_pkg.sv
mem_bus_if.sv
fetch_unit.sv
decoder.sv
register_file.sv
execute_unit.sv
load_store_unit.sv
bus_arbiter.sv
rv_core_top.sv
tb_clock_gen.sv
tb_core.sv

// File: register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic                          clock,
	input  logic [rv_pkg::reg_addr_w-1:0] raddr1,
	input  logic [rv_pkg::reg_addr_w-1:0] raddr2,
	output logic [rv_pkg::xlen-1:0]       rdata1,
	output logic [rv_pkg::xlen-1:0]       rdata2,
	input  logic [rv_pkg::reg_addr_w-1:0] waddr,
	input  logic [rv_pkg::xlen-1:0]       wdata,
	input  logic                          wen
);

	logic [rv_pkg::xlen-1:0] regs [2**rv_pkg::reg_addr_w];

	always_ff @(posedge clock) begin
		if (wen && waddr != '0)
			regs[waddr] <= wdata;
	end

	// x0 is hardwired
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top #(
	parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
	input  logic                    clock,
	input  logic                    rst,
	output logic                    mem_req_valid,
	input  logic                    mem_req_ready,
	output logic [rv_pkg::xlen-1:0] mem_addr,
	output logic [rv_pkg::xlen-1:0] mem_wdata,
	output logic [3:0]              mem_wstrb,
	output logic                    mem_we,
	input  logic                    mem_resp_valid,
	input  logic [rv_pkg::xlen-1:0] mem_rdata,
	input  logic                    mem_resp_err,
	output logic                    retire_valid,
	output logic [rv_pkg::xlen-1:0] retire_pc,
	output logic                    halted
);

	rv_pkg::seq_state_e      state, state_next;
	rv_pkg::decoded_t        dec;
	logic                    start_sent;
	logic                    fetch_start, fetch_done, fetch_error;
	logic                    lsu_start, lsu_done, lsu_error;
	logic [rv_pkg::xlen-1:0] pc, pc_next, inst;
	logic [rv_pkg::xlen-1:0] src1, src2, result, data_addr, load_data, wb_data;
	logic                    in_writeback;

	mem_bus_if fetch_bus ();
	mem_bus_if lsu_bus ();

	// ============================================================
	// Sequencer
	// ============================================================
	assign fetch_start  = state == rv_pkg::st_fetch && !start_sent;  // one pulse per entry
	assign lsu_start    = state == rv_pkg::st_memory && !start_sent;
	assign in_writeback = state == rv_pkg::st_writeback;

	always_comb begin
		state_next = state;
		case (state)
			rv_pkg::st_fetch:
				if (fetch_done)
					state_next = fetch_error ? rv_pkg::st_halt : rv_pkg::st_execute;
			rv_pkg::st_execute:
				if (dec.illegal || dec.is_ebreak)
					state_next = rv_pkg::st_halt;
				else if (dec.is_load || dec.is_store)
					state_next = rv_pkg::st_memory;
				else
					state_next = rv_pkg::st_writeback;
			rv_pkg::st_memory:
				if (lsu_done)
					state_next = lsu_error ? rv_pkg::st_halt : rv_pkg::st_writeback;
			rv_pkg::st_writeback: state_next = rv_pkg::st_fetch;
			default: state_next = rv_pkg::st_halt;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state      <= rv_pkg::st_fetch;
			start_sent <= 1'b0;
		end else begin
			state <= state_next;
			if (state_next != state)
				start_sent <= 1'b0;
			else if (fetch_start || lsu_start)
				start_sent <= 1'b1;
		end
	end

	assign retire_valid = in_writeback;
	assign retire_pc    = pc; // PC moves on at the end of writeback
	assign halted       = state == rv_pkg::st_halt;
	assign wb_data      = dec.is_load ? load_data : result;

	fetch_unit #(.reset_pc(reset_pc)) fetch_unit_i (
		.clock(clock), .rst(rst), .bus(fetch_bus.requester),
		.start(fetch_start), .pc_next(pc_next), .pc_load(in_writeback),
		.pc(pc), .inst(inst), .done(fetch_done), .error(fetch_error)
	);

	decoder decoder_i (.inst(inst), .dec(dec));

	register_file register_file_i (
		.clock(clock), .raddr1(dec.rs1), .raddr2(dec.rs2),
		.rdata1(src1), .rdata2(src2),
		.waddr(dec.rd), .wdata(wb_data), .wen(in_writeback && dec.reg_wen)
	);

	execute_unit execute_unit_i (
		.dec(dec), .src1(src1), .src2(src2), .pc(pc),
		.result(result), .pc_next(pc_next), .mem_addr(data_addr)
	);

	load_store_unit load_store_unit_i (
		.clock(clock), .rst(rst), .bus(lsu_bus.requester),
		.start(lsu_start), .dec(dec), .addr(data_addr), .store_data(src2),
		.load_data(load_data), .done(lsu_done), .error(lsu_error)
	);

	bus_arbiter bus_arbiter_i (
		.clock(clock), .rst(rst),
		.fetch_bus(fetch_bus.arbiter), .lsu_bus(lsu_bus.arbiter),
		.mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
		.mem_we(mem_we), .mem_resp_valid(mem_resp_valid),
		.mem_rdata(mem_rdata), .mem_resp_err(mem_resp_err)
	);

endmodule

// File: rv_pkg.sv
package rv_pkg;

	parameter int xlen = 32;
	parameter int reg_addr_w = 4; // RV32E has sixteen registers

	// Major opcodes, bits [6:0] of the instruction
	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_auipc  = 7'b0010111,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_branch = 7'b1100011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_imm    = 7'b0010011,
		op_reg    = 7'b0110011,
		op_system = 7'b1110011
	} opcode_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_slt,
		alu_and,
		alu_or,
		alu_xor,
		alu_pass_b
	} alu_op_e;

	typedef enum logic [2:0] {
		st_fetch,
		st_execute,
		st_memory,
		st_writeback,
		st_halt
	} seq_state_e;

	typedef struct packed {
		opcode_e               opcode;
		logic [reg_addr_w-1:0] rd;
		logic [reg_addr_w-1:0] rs1;
		logic [reg_addr_w-1:0] rs2;
		logic [2:0]            funct3;
		logic [xlen-1:0]       imm;
		alu_op_e               alu_op;
		logic                  reg_wen;
		logic                  is_load;
		logic                  is_store;
		logic                  is_branch;
		logic                  is_jump;
		logic                  is_ebreak;
		logic                  illegal;
	} decoded_t;

endpackage

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clock,
	output logic rst
);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock; // 20 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (3) @(posedge clock);
		rst <= 1'b0;
	end

endmodule

// File: tb_core.sv
`timescale 1ns/1ps

module tb_core;

	localparam logic [31:0] reset_pc    = 32'h0000_0000;
	localparam logic [31:0] ebreak_word = 32'h0010_0073;

	logic        clock;
	logic        rst_init;
	logic        rerun_rst      = 1'b0;
	logic        rst;
	logic        mem_req_valid;
	logic        mem_req_ready  = 1'b0;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic [3:0]  mem_wstrb;
	logic        mem_we;
	logic        mem_resp_valid = 1'b0;
	logic [31:0] mem_rdata      = 32'h0;
	logic        mem_resp_err   = 1'b0;
	logic        retire_valid;
	logic [31:0] retire_pc;
	logic        halted;

	// Memory model state
	logic [31:0] mem [1024];
	logic        pending;
	logic [1:0]  wait_cnt;
	logic [31:0] acc_addr;
	logic        acc_we;
	logic [31:0] err_addr;
	logic [31:0] wr_addr_q[$];
	logic [31:0] wr_data_q[$];
	integer      seed = 91948;

	// Reference model state
	logic [31:0] shadow_mem [1024];
	logic [31:0] shadow_regs [16];
	logic [31:0] shadow_pc;
	logic        exp_store;
	logic [31:0] exp_st_addr;
	logic [31:0] exp_st_data;
	logic [31:0] prog[$];
	logic [31:0] halt_pc;
	int          retire_count;
	string       test_name;

	assign rst = rst_init | rerun_rst;

	tb_clock_gen clock_gen_i (.clock(clock), .rst(rst_init));

	rv_core_top #(.reset_pc(reset_pc)) rv_core_top_i (
		.clock(clock), .rst(rst),
		.mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
		.mem_we(mem_we), .mem_resp_valid(mem_resp_valid),
		.mem_rdata(mem_rdata), .mem_resp_err(mem_resp_err),
		.retire_valid(retire_valid), .retire_pc(retire_pc), .halted(halted)
	);

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic value_mismatch(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		stop_run($sformatf("error %s %s: expected %h, actual %h", test_name, what, exp, act));
	endtask

	// ============================================================
	// Instruction encoders
	// ============================================================
	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011}; // SW
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	// ============================================================
	// Reference instruction model
	// ============================================================
	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
			input logic [31:0] a, input logic [31:0] b);
		logic [31:0] r;
		case (f3)
			3'b000:  r = sub ? a - b : a + b;
			3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b100:  r = a ^ b;
			3'b110:  r = a | b;
			3'b111:  r = a & b;
			default: r = 32'h0;
		endcase
		return r;
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		logic t;
		case (f3)
			3'b000:  t = a == b;
			3'b001:  t = a != b;
			3'b100:  t = $signed(a) < $signed(b);
			3'b101:  t = $signed(a) >= $signed(b);
			3'b110:  t = a < b;
			default: t = a >= b; // BGEU
		endcase
		return t;
	endfunction

	// Executes one instruction on the shadow state, returns its PC
	function automatic logic [31:0] rv_step();
		logic [31:0] ins, pc_now, a, b, res, nxt, addr;
		logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
		logic        wr;
		ins    = shadow_mem[shadow_pc[11:2]];
		pc_now = shadow_pc;
		a      = shadow_regs[ins[18:15]];
		b      = shadow_regs[ins[23:20]];
		imm_i  = {{20{ins[31]}}, ins[31:20]};
		imm_s  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		imm_b  = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_u  = {ins[31:12], 12'h000};
		imm_j  = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		res       = 32'h0;
		addr      = 32'h0;
		nxt       = pc_now + 32'd4;
		wr        = 1'b1;
		exp_store = 1'b0;
		case (ins[6:0])
			7'h37: res = imm_u;
			7'h17: res = pc_now + imm_u;
			7'h6f: begin
				res = pc_now + 32'd4;
				nxt = pc_now + imm_j;
			end
			7'h67: begin
				res = pc_now + 32'd4;
				nxt = (a + imm_i) & 32'hffff_fffe;
			end
			7'h63: begin
				wr = 1'b0;
				if (branch_taken(ins[14:12], a, b))
					nxt = pc_now + imm_b;
			end
			7'h03: begin
				addr = a + imm_i;
				res  = shadow_mem[addr[11:2]];
			end
			7'h23: begin
				wr          = 1'b0;
				addr        = a + imm_s;
				shadow_mem[addr[11:2]] = b;
				exp_store   = 1'b1;
				exp_st_addr = addr;
				exp_st_data = b;
			end
			7'h13: res = alu_ref(ins[14:12], 1'b0, a, imm_i);
			7'h33: res = alu_ref(ins[14:12], ins[30], a, b);
			default: wr = 1'b0;
		endcase
		if (wr && ins[11:7] != 5'd0)
			shadow_regs[ins[10:7]] = res;
		shadow_pc = nxt;
		return pc_now;
	endfunction

	// ============================================================
	// Programs
	// ============================================================
	task automatic build_main_program();
		int r;
		prog = {};
		prog.push_back(i_type(12'h100, 0, 3'b000, 1, 7'h13)); // x1 = data base
		prog.push_back(i_type(25, 0, 3'b000, 2, 7'h13));
		prog.push_back(i_type(-7, 0, 3'b000, 3, 7'h13));
		prog.push_back(r_type(7'h00, 3, 2, 3'b000, 4));
		prog.push_back(r_type(7'h20, 2, 3, 3'b000, 5)); // SUB
		prog.push_back(r_type(7'h00, 2, 3, 3'b010, 6));
		prog.push_back(r_type(7'h00, 3, 2, 3'b111, 7));
		prog.push_back(r_type(7'h00, 3, 2, 3'b110, 8));
		prog.push_back(r_type(7'h00, 3, 2, 3'b100, 9));
		prog.push_back(i_type(-1, 3, 3'b010, 10, 7'h13));
		prog.push_back(i_type(12'h00f, 2, 3'b111, 11, 7'h13));
		prog.push_back(i_type(12'h070, 3, 3'b110, 12, 7'h13));
		prog.push_back(i_type(-1, 2, 3'b100, 13, 7'h13));
		prog.push_back(u_type(20'h12345, 14, 7'h37));
		prog.push_back(u_type(20'h00001, 15, 7'h17));
		for (r = 4; r < 16; r++)
			prog.push_back(s_type((r - 4) * 4, r, 1));
		// Each branch pair has one taken and one not taken
		prog.push_back(b_type(8, 2, 2, 3'b000));
		prog.push_back(i_type(99, 0, 3'b000, 6, 7'h13));
		prog.push_back(b_type(8, 2, 2, 3'b001));
		prog.push_back(b_type(8, 2, 3, 3'b100));
		prog.push_back(i_type(99, 0, 3'b000, 6, 7'h13));
		prog.push_back(b_type(8, 2, 3, 3'b101));
		prog.push_back(b_type(8, 3, 2, 3'b110));
		prog.push_back(i_type(99, 0, 3'b000, 6, 7'h13));
		prog.push_back(b_type(8, 3, 2, 3'b111));
		prog.push_back(i_type(3, 0, 3'b000, 13, 7'h13)); // Backward loop of three passes
		prog.push_back(i_type(-1, 13, 3'b000, 13, 7'h13));
		prog.push_back(b_type(-4, 0, 13, 3'b001));
		prog.push_back(j_type(8, 7));
		prog.push_back(i_type(99, 0, 3'b000, 6, 7'h13));
		prog.push_back(i_type((prog.size() + 3) * 4, 0, 3'b000, 8, 7'h13));
		prog.push_back(i_type(0, 8, 3'b000, 9, 7'h67)); // JALR
		prog.push_back(i_type(99, 0, 3'b000, 6, 7'h13));
		prog.push_back(s_type(48, 7, 1));
		prog.push_back(s_type(52, 9, 1));
		prog.push_back(s_type(56, 6, 1));
		prog.push_back(i_type(4, 1, 3'b010, 10, 7'h03)); // LW of an earlier store
		prog.push_back(s_type(60, 10, 1));
		prog.push_back(i_type(60, 1, 3'b010, 11, 7'h03));
		prog.push_back(r_type(7'h00, 10, 11, 3'b000, 12));
		prog.push_back(s_type(64, 12, 1));
		halt_pc = prog.size() * 4;
		prog.push_back(ebreak_word);
	endtask

	task automatic build_error_program();
		prog = {};
		prog.push_back(i_type(12'h200, 0, 3'b000, 1, 7'h13));
		prog.push_back(i_type(0, 1, 3'b010, 2, 7'h03)); // answered with a bus error
		prog.push_back(i_type(5, 0, 3'b000, 3, 7'h13));
		prog.push_back(ebreak_word);
	endtask

	task automatic load_program();
		int i;
		for (i = 0; i < 1024; i++) begin
			mem[i]        = 32'hd00d_0000 | i;
			shadow_mem[i] = 32'hd00d_0000 | i;
		end
		for (i = 0; i < prog.size(); i++) begin
			mem[i]        = prog[i];
			shadow_mem[i] = prog[i];
		end
	endtask

	// ============================================================
	// Memory model
	// ============================================================
	always @(posedge clock) begin
		if (rst) begin
			mem_req_ready  <= 1'b0;
			mem_resp_valid <= 1'b0;
			mem_resp_err   <= 1'b0;
			pending        <= 1'b0;
		end else begin
			mem_req_ready  <= ($random(seed) & 3) != 0; // ready three cycles in four
			mem_resp_valid <= 1'b0;
			mem_resp_err   <= 1'b0;
			if (pending) begin
				if (wait_cnt == 2'd0) begin
					mem_resp_valid <= 1'b1;
					mem_rdata      <= acc_we ? 32'h0 : mem[acc_addr[11:2]];
					mem_resp_err   <= !acc_we && acc_addr == err_addr;
					pending        <= 1'b0;
				end else begin
					wait_cnt <= wait_cnt - 2'd1;
				end
			end else if (mem_req_valid && mem_req_ready) begin
				assert (!mem_we || mem_wstrb == 4'hf)
					else value_mismatch("store_strobes", 32'hf, mem_wstrb);
				pending  <= 1'b1;
				wait_cnt <= $unsigned($random(seed)) % 3;
				acc_addr <= mem_addr;
				acc_we   <= mem_we;
				if (mem_we) begin
					mem[mem_addr[11:2]] <= mem_wdata;
					wr_addr_q.push_back(mem_addr);
					wr_data_q.push_back(mem_wdata);
				end
			end
		end
	end

	// Retire checker
	always @(negedge clock) begin : retire_check
		logic [31:0] exp_pc;
		logic [31:0] got_addr;
		logic [31:0] got_data;
		// DUT registers are unknown until the first clock edge
		if (rst && $time > 0)
			assert (!mem_req_valid) else stop_run("memory request raised during reset");
		if (!rst && retire_valid) begin
			exp_pc = rv_step();
			retire_count++;
			assert (retire_pc == exp_pc) else value_mismatch("retire_pc", exp_pc, retire_pc);
			if (exp_store) begin
				assert (wr_addr_q.size() == 1)
					else stop_run("a store retired without exactly one write at the memory port");
				got_addr = wr_addr_q.pop_front();
				got_data = wr_data_q.pop_front();
				assert (got_addr == exp_st_addr)
					else value_mismatch("store_addr", exp_st_addr, got_addr);
				assert (got_data == exp_st_data)
					else value_mismatch("store_data", exp_st_data, got_data);
			end else begin
				assert (wr_addr_q.size() == 0)
					else stop_run("a non-store instruction wrote to the memory port");
			end
		end
	end

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		do begin
			@(negedge clock);
			cycles++;
			if (cycles >= 2000)
				stop_run("timeout: reset was never released");
		end while (rst);
	endtask

	task automatic wait_for_halt();
		int idle;
		idle = 0;
		while (!halted) begin
			@(negedge clock);
			if (retire_valid)
				idle = 0;
			else
				idle++;
			if (idle >= 2000)
				stop_run("timeout: the core stopped retiring for 2000 cycles and never halted");
		end
	endtask

	task automatic watch_halted(input int cycles);
		repeat (cycles) begin
			@(negedge clock);
			assert (halted && !mem_req_valid && !retire_valid)
				else stop_run("the halted core left halt, made a memory request or retired");
		end
	endtask

	initial begin
		test_name = "main_program";
		err_addr  = 32'hffff_ffff; // no bus errors in the first run
		foreach (shadow_regs[i])
			shadow_regs[i] = 32'h0;
		build_main_program();
		load_program();
		shadow_pc    = reset_pc;
		retire_count = 0;
		wait_reset_release();
		wait_for_halt();
		assert (shadow_pc == halt_pc) else value_mismatch("halt_pc", halt_pc, shadow_pc);
		assert (wr_addr_q.size() == 0)
			else stop_run("the memory port saw a write that no store retired");
		watch_halted(50);

		// Second run with the load answered by resp_err
		test_name = "bus_error";
		@(posedge clock);
		rerun_rst <= 1'b1;
		build_error_program();
		load_program();
		err_addr     = 32'h0000_0200;
		shadow_pc    = reset_pc;
		retire_count = 0;
		repeat (3) @(posedge clock);
		rerun_rst <= 1'b0;
		wait_for_halt();
		assert (retire_count == 1) else value_mismatch("retire_count", 1, retire_count);
		watch_halted(50);

		$display("Done: no errors");
		$finish;
	end

endmodule
